//--- dv/tb_text_display.sv
// text display subsystem testbench
`timescale 1ns/1ps

module tb_text_display;
    import vram_pkg::*;

    localparam int MAX_CASES    = 64;
    localparam int FRAME_PIXELS = TEXT_COLS * TEXT_ROWS * GLYPH_H * GLYPH_W;

    logic        clk = 1'b0;
    logic        reset;
    logic        host_wr;
    logic        host_rd;
    vram_addr_t  host_addr;
    vram_data_t  host_wdata;
    vram_mask_t  host_mask;
    logic        host_busy;
    logic        host_rd_valid;
    vram_data_t  host_rdata;
    logic        pix_valid;
    logic        frame_start;
    color_t      pix_color;

    logic [15:0] cases [0:4*MAX_CASES-1];   // cmd, addr, data, mask per case
    vram_data_t  model [0:VRAM_DEPTH-1];
    int          num_cases;
    int          errors = 0;
    int          fails = 0;
    logic        cases_loaded = 1'b0;
    logic        valid_seen = 1'b0;
    int          cycle = 0;
    int          last_frame = -1;
    integer      seed;

    always #50 clk = ~clk;

    text_display_top UUT (
        .clk           (clk),
        .reset         (reset),
        .host_wr       (host_wr),
        .host_rd       (host_rd),
        .host_addr     (host_addr),
        .host_wdata    (host_wdata),
        .host_mask     (host_mask),
        .host_busy     (host_busy),
        .host_rd_valid (host_rd_valid),
        .host_rdata    (host_rdata),
        .pix_valid     (pix_valid),
        .frame_start   (frame_start),
        .pix_color     (pix_color)
    );

    function automatic void model_write(vram_addr_t addr, vram_data_t data, vram_mask_t mask);
        for (int n = 0; n < 4; n++) begin
            if (mask[n]) begin
                model[addr][n*4 +: 4] = data[n*4 +: 4];
            end
        end
    endfunction

    // colour of pixel p counted from frame_start
    function automatic color_t expected_pixel(int p);
        int         line;
        int         col;
        int         bit_idx;
        vram_data_t map_word;
        vram_data_t font_word;
        logic [7:0] glyph;
        line      = p / (TEXT_COLS * GLYPH_W);   // screen line 0..15
        col       = (p / GLYPH_W) % TEXT_COLS;
        bit_idx   = GLYPH_W - 1 - (p % GLYPH_W);
        map_word  = model[vram_addr_t'(MAP_BASE + (line / GLYPH_H) * TEXT_COLS + col)];
        font_word = model[vram_addr_t'(FONT_BASE + 4 * map_word[7:0] + (line % GLYPH_H) / 2)];
        glyph     = (line % 2 == 1) ? font_word[7:0] : font_word[15:8];
        return glyph[bit_idx] ? map_word[11:8] : map_word[15:12];
    endfunction

    task automatic check_data(input string name, input vram_data_t got, input vram_data_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_color(input string name, input color_t got, input color_t exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // starts and ends on a falling edge with host_busy low
    task automatic host_access(input logic is_wr, input vram_addr_t addr,
                               input vram_data_t wdata, input vram_mask_t mask,
                               output vram_data_t rdata);
        int busy_cycles;
        busy_cycles = 0;
        rdata       = '0;
        host_wr     = is_wr;
        host_rd     = !is_wr;
        host_addr   = addr;
        host_wdata  = wdata;
        host_mask   = mask;
        @(negedge clk);
        host_wr = 1'b0;
        host_rd = 1'b0;
        if (!host_busy) begin
            $display("error: host_busy did not rise after the strobe to %h", addr);
            errors++;
        end
        while (host_busy) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (busy_cycles > 3) begin
            $display("error: access to %h held host_busy for %0d cycles", addr, busy_cycles);
            errors++;
        end
        if (is_wr) begin
            model_write(addr, wdata, mask);   // write is done once busy falls
        end else if (!host_rd_valid) begin
            $display("error: no host_rd_valid after the read of %h", addr);
            errors++;
        end else begin
            rdata = host_rdata;
        end
    endtask

    task automatic check_frame();
        // the first frame may still hold cells fetched before the last write
        for (int k = 0; k < 2; k++) begin
            @(negedge clk);
            while (!frame_start) begin
                @(negedge clk);
            end
        end
        if (!pix_valid) begin
            $display("error: pix_valid %h at frame_start", pix_valid);
            errors++;
        end
        for (int p = 0; p < FRAME_PIXELS; p++) begin
            check_color($sformatf("pix_color[%0d]", p), pix_color, expected_pixel(p));
            @(negedge clk);
        end
    endtask

    // pixel stream continuity
    always @(negedge clk) begin
        cycle++;
        if (pix_valid) begin
            valid_seen = 1'b1;
        end else if (valid_seen) begin
            $display("pix_valid dropped at cycle %0d", cycle);
            errors++;
        end
        if (frame_start) begin
            if (last_frame >= 0 && cycle - last_frame != FRAME_PIXELS) begin
                $display("frame_start came %0d cycles after the previous one",
                         cycle - last_frame);
                errors++;
            end
            last_frame = cycle;
        end
    end

    initial begin
        wait (cases_loaded);
        repeat (num_cases * 5000 + 10 * FRAME_PIXELS) @(posedge clk);
        $display("timeout, the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        vram_data_t rdata;
        vram_addr_t addr;
        vram_data_t data;
        vram_mask_t mask;
        logic [15:0] cmd;
        string      kind;
        int         errors_before;
        reset      = 1'b1;
        host_wr    = 1'b0;
        host_rd    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        host_mask  = '0;
        for (int i = 0; i < 4 * MAX_CASES; i++) begin
            cases[i] = '0;
        end
        for (int i = 0; i < VRAM_DEPTH; i++) begin
            model[i] = 16'hdead;
        end
        $readmemh("dv/text_display_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[4*num_cases] != 16'h0) begin
            num_cases++;
        end
        cases_loaded = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // status outputs idle straight out of reset
        if (host_busy || host_rd_valid || pix_valid || frame_start) begin
            $display("error: host_busy %h host_rd_valid %h pix_valid %h frame_start %h",
                     host_busy, host_rd_valid, pix_valid, frame_start);
            errors++;
        end

        // random map and full font
        seed = 32'h1691_e2d9;
        for (int i = 0; i < TEXT_COLS * TEXT_ROWS; i++) begin
            host_access(1'b1, vram_addr_t'(MAP_BASE + i), vram_data_t'($random(seed)), 4'hf,
                        rdata);
        end
        for (int i = 0; i < 256 * 4; i++) begin
            host_access(1'b1, vram_addr_t'(FONT_BASE + i), vram_data_t'($random(seed)), 4'hf,
                        rdata);
        end
        $display("fill map and font %s", (errors == 0) ? "ok" : "FAIL");
        if (errors != 0) begin
            fails++;
        end

        for (int c = 0; c < num_cases; c++) begin
            cmd           = cases[4*c];
            addr          = cases[4*c+1][VRAM_ADDR_W-1:0];
            data          = cases[4*c+2];
            mask          = cases[4*c+3][3:0];
            errors_before = errors;
            case (cmd)
                16'h1: begin
                    kind = "write";
                    host_access(1'b1, addr, data, mask, rdata);
                end
                16'h2: begin
                    kind = "read";
                    host_access(1'b0, addr, '0, '0, rdata);
                    check_data("host_rdata", rdata, data);
                    if (model[addr] !== data) begin
                        $display("case %0d expects %h but the model holds %h",
                                 c, data, model[addr]);
                        errors++;
                    end
                end
                16'h3: begin
                    kind = "frame";
                    check_frame();
                end
                default: begin
                    kind = "unknown";
                    $display("case %0d has an unknown command %h", c, cmd);
                    errors++;
                end
            endcase
            if (errors != errors_before) begin
                fails++;
            end
            $display("case %0d %s %h %s", c, kind, addr,
                     (errors == errors_before) ? "ok" : "FAIL");
        end

        $display("%0d tests run, %0d with errors, %0d errors in all",
                 num_cases + 1, fails, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- dv/text_display_cases.txt
// columns: cmd addr data mask, all hex
// cmd 1 write data under the nibble mask, 2 read and expect data, 3 check one frame
1 0100 1234 f
2 0100 1234 0
1 0100 abcd 5
2 0100 1b3d 0
1 0101 5a5a 8
2 0101 5ead 0
2 0200 dead 0
3 0000 0000 0
1 0000 2141 f
1 0005 7f00 f
1 0003 c3aa 3
3 0000 0000 0
1 0300 0f0f f
1 0301 f0f0 f
2 0300 0f0f 0
2 0301 f0f0 0
1 0300 ffff 2
2 0300 0fff 0
1 0007 0000 f
3 0000 0000 0

//--- run_sim.sh
#!/bin/bash
# build the text display testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log obj_dir/tb_sim
verilator --binary --timing --assert -f sim.f --top-module tb_text_display -o tb_sim \
    > build.log 2>&1 && ./obj_dir/tb_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat build.log sim.log
grep -q "Test passed" sim.log || echo "Test failed" >> sim.log
grep -q "Test failed" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- sim.f
verilog/vram_pkg.sv
verilog/vram.sv
verilog/vram_slot_arbiter.sv
verilog/text_fetch.sv
verilog/pixel_shifter.sv
verilog/text_display_top.sv
dv/tb_text_display.sv

//--- verilog/pixel_shifter.sv
// glyph line to pixel shifter
`timescale 1ns/1ps

module pixel_shifter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  logic                         first_of_frame,
    input  logic [vram_pkg::GLYPH_W-1:0] glyph_bits,
    input  vram_pkg::color_t             fg,
    input  vram_pkg::color_t             bg,
    output logic                         pix_valid,
    output logic                         frame_start,
    output vram_pkg::color_t             pix_color
);
    import vram_pkg::*;

    logic [GLYPH_W-1:0] bits;
    color_t             fg_q;
    color_t             bg_q;

    always_ff @(posedge clk) begin
        if (load) begin
            bits <= glyph_bits;
            fg_q <= fg;
            bg_q <= bg;
        end else begin
            bits <= bits << 1;   // msb is the current pixel
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_valid   <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            if (load) begin
                pix_valid <= 1'b1;   // loads keep coming every 8 clocks
            end
            frame_start <= load && first_of_frame;
        end
    end

    assign pix_color = bits[GLYPH_W-1] ? fg_q : bg_q;

endmodule

//--- verilog/text_display_top.sv
// text display subsystem top
`timescale 1ns/1ps

module text_display_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 host_wr,
    input  logic                 host_rd,
    input  vram_pkg::vram_addr_t host_addr,
    input  vram_pkg::vram_data_t host_wdata,
    input  vram_pkg::vram_mask_t host_mask,
    output logic                 host_busy,
    output logic                 host_rd_valid,
    output vram_pkg::vram_data_t host_rdata,
    output logic                 pix_valid,
    output logic                 frame_start,
    output vram_pkg::color_t     pix_color
);
    import vram_pkg::*;

    slot_t              slot;
    logic               mem_sel;
    logic               mem_wr;
    vram_mask_t         mem_mask;
    vram_addr_t         mem_addr;
    vram_data_t         mem_wdata;
    vram_data_t         mem_rdata;
    vram_addr_t         fetch_map_addr;
    vram_addr_t         fetch_font_addr;
    logic               load;
    logic               first_of_frame;
    logic [GLYPH_W-1:0] glyph_bits;
    color_t             fg;
    color_t             bg;

    vram_slot_arbiter u_arbiter (
        .clk             (clk),
        .reset           (reset),
        .host_wr         (host_wr),
        .host_rd         (host_rd),
        .host_addr       (host_addr),
        .host_wdata      (host_wdata),
        .host_mask       (host_mask),
        .host_busy       (host_busy),
        .host_rd_valid   (host_rd_valid),
        .host_rdata      (host_rdata),
        .fetch_map_addr  (fetch_map_addr),
        .fetch_font_addr (fetch_font_addr),
        .slot            (slot),
        .mem_sel         (mem_sel),
        .mem_wr          (mem_wr),
        .mem_mask        (mem_mask),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata)
    );

    vram u_vram (
        .clk   (clk),
        .sel   (mem_sel),
        .wr    (mem_wr),
        .mask  (mem_mask),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    text_fetch u_fetch (
        .clk             (clk),
        .reset           (reset),
        .slot            (slot),
        .mem_rdata       (mem_rdata),
        .fetch_map_addr  (fetch_map_addr),
        .fetch_font_addr (fetch_font_addr),
        .load            (load),
        .first_of_frame  (first_of_frame),
        .glyph_bits      (glyph_bits),
        .fg              (fg),
        .bg              (bg)
    );

    pixel_shifter u_shifter (
        .clk            (clk),
        .reset          (reset),
        .load           (load),
        .first_of_frame (first_of_frame),
        .glyph_bits     (glyph_bits),
        .fg             (fg),
        .bg             (bg),
        .pix_valid      (pix_valid),
        .frame_start    (frame_start),
        .pix_color      (pix_color)
    );

endmodule

//--- verilog/text_fetch.sv
// text cell fetch
// scans the grid and pulls map and font words per cell
`timescale 1ns/1ps

module text_fetch (
    input  logic                         clk,
    input  logic                         reset,
    input  vram_pkg::slot_t              slot,
    input  vram_pkg::vram_data_t         mem_rdata,
    output vram_pkg::vram_addr_t         fetch_map_addr,
    output vram_pkg::vram_addr_t         fetch_font_addr,
    output logic                         load,
    output logic                         first_of_frame,
    output logic [vram_pkg::GLYPH_W-1:0] glyph_bits,
    output vram_pkg::color_t             fg,
    output vram_pkg::color_t             bg
);
    import vram_pkg::*;

    logic [COL_W-1:0]  col;
    logic [LINE_W-1:0] line;
    logic [ROW_W-1:0]  row;
    vram_data_t        map_word;
    vram_data_t        font_word;
    logic [7:0]        char_code;

    // scan position moves on after each handoff
    always_ff @(posedge clk) begin
        if (reset) begin
            col  <= '0;
            line <= '0;
            row  <= '0;
        end else if (load) begin
            if (col == COL_W'(TEXT_COLS - 1)) begin
                col <= '0;
                if (line == LINE_W'(GLYPH_H - 1)) begin
                    line <= '0;
                    row  <= (row == ROW_W'(TEXT_ROWS - 1)) ? '0 : row + 1'b1;
                end else begin
                    line <= line + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // one slot before the handoff slot
    always_ff @(posedge clk) begin
        if (reset) begin
            load <= 1'b0;
        end else begin
            load <= (slot == SLOT_LOAD - 3'd1);
        end
    end

    // read data lands one slot after each issue
    always_ff @(posedge clk) begin
        if (slot == slot_t'(SLOT_MAP_RD + 3'd1)) begin
            map_word <= mem_rdata;
        end
        if (slot == slot_t'(SLOT_FONT_RD + 3'd1)) begin
            font_word <= mem_rdata;
        end
    end

    assign char_code = map_word[7:0];

    assign fetch_map_addr  = vram_addr_t'(MAP_BASE + row * TEXT_COLS + col);
    assign fetch_font_addr = vram_addr_t'(FONT_BASE + {char_code, 2'b00}
                                          + line[LINE_W-1:1]);   // two lines per word

    assign glyph_bits     = line[0] ? font_word[7:0] : font_word[15:8];
    assign fg             = map_word[11:8];
    assign bg             = map_word[15:12];
    assign first_of_frame = load && (col == '0) && (line == '0) && (row == '0);

    // handoff register and slot counter must stay in step
    a_load_slot: assert property (@(posedge clk) disable iff (reset)
        load |-> (slot == SLOT_LOAD))
        else $error("load outside its slot");

endmodule

//--- verilog/vram.sv
// video memory
// nibble masked word array with registered read
`timescale 1ns/1ps

module vram (
    input  logic                 clk,
    input  logic                 sel,
    input  logic                 wr,
    input  vram_pkg::vram_mask_t mask,
    input  vram_pkg::vram_addr_t addr,
    input  vram_pkg::vram_data_t wdata,
    output vram_pkg::vram_data_t rdata
);
    import vram_pkg::*;

    vram_data_t mem [0:VRAM_DEPTH-1];

    // unwritten words read back as a marker
    initial begin
        for (int i = 0; i < VRAM_DEPTH; i++) begin
            mem[i] = 16'hdead;
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            if (wr) begin
                for (int n = 0; n < 4; n++) begin
                    if (mask[n]) begin
                        mem[addr][n*4 +: 4] <= wdata[n*4 +: 4];
                    end
                end
            end
            rdata <= mem[addr];   // old word on a write
        end
    end

    // the arbiter only writes inside a selected access
    a_wr_needs_sel: assert property (@(posedge clk) wr |-> sel)
        else $error("vram write without select");

endmodule

//--- verilog/vram_pkg.sv
// text display shared definitions
package vram_pkg;

    // memory geometry
    localparam int VRAM_ADDR_W = 12;
    localparam int VRAM_DEPTH  = 1 << VRAM_ADDR_W;

    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;   // word address
    typedef logic [15:0]            vram_data_t;
    typedef logic [3:0]             vram_mask_t;   // bit n covers data[4n+3:4n]
    typedef logic [3:0]             color_t;       // colour index
    typedef logic [2:0]             slot_t;        // memory access slot

    // text grid
    localparam int TEXT_COLS = 4;
    localparam int TEXT_ROWS = 2;
    localparam int GLYPH_H   = 8;
    localparam int GLYPH_W   = 8;
    localparam int COL_W     = $clog2(TEXT_COLS);
    localparam int LINE_W    = $clog2(GLYPH_H);
    localparam int ROW_W     = $clog2(TEXT_ROWS);

    // tile map, one word per cell, row major from MAP_BASE
    //   [7:0]   character code
    //   [11:8]  fg colour
    //   [15:12] bg colour
    localparam vram_addr_t MAP_BASE = 12'h000;

    // font, 4 words per character code
    // word k holds glyph line 2k in [15:8] and line 2k+1 in [7:0]
    localparam vram_addr_t FONT_BASE = 12'h800;

    // fixed access slots, all others belong to the host
    localparam slot_t SLOT_MAP_RD  = 3'd0;
    localparam slot_t SLOT_FONT_RD = 3'd2;
    localparam slot_t SLOT_LOAD    = 3'd7;     // fetch hands the cell to the shifter

endpackage

//--- verilog/vram_slot_arbiter.sv
// slot based memory arbiter
`timescale 1ns/1ps

module vram_slot_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 host_wr,
    input  logic                 host_rd,
    input  vram_pkg::vram_addr_t host_addr,
    input  vram_pkg::vram_data_t host_wdata,
    input  vram_pkg::vram_mask_t host_mask,
    output logic                 host_busy,
    output logic                 host_rd_valid,
    output vram_pkg::vram_data_t host_rdata,
    input  vram_pkg::vram_addr_t fetch_map_addr,
    input  vram_pkg::vram_addr_t fetch_font_addr,
    output vram_pkg::slot_t      slot,
    output logic                 mem_sel,
    output logic                 mem_wr,
    output vram_pkg::vram_mask_t mem_mask,
    output vram_pkg::vram_addr_t mem_addr,
    output vram_pkg::vram_data_t mem_wdata,
    input  vram_pkg::vram_data_t mem_rdata
);
    import vram_pkg::*;

    vram_addr_t held_addr;
    vram_data_t held_wdata;
    vram_mask_t held_mask;
    logic       held_wr;
    logic       host_slot;
    logic       host_exec;

    // free running, wraps after 7
    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
        end else begin
            slot <= slot + 3'd1;
        end
    end

    assign host_slot = (slot != SLOT_MAP_RD) && (slot != SLOT_FONT_RD);
    assign host_exec = host_busy && host_slot;

    // one entry holding register
    always_ff @(posedge clk) begin
        if (!host_busy && (host_wr || host_rd)) begin
            held_addr  <= host_addr;
            held_wdata <= host_wdata;
            held_mask  <= host_mask;
            held_wr    <= host_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            host_busy     <= 1'b0;
            host_rd_valid <= 1'b0;
        end else begin
            if (host_exec) begin
                host_busy <= 1'b0;
            end else if (host_wr || host_rd) begin
                host_busy <= 1'b1;
            end
            host_rd_valid <= host_exec && !held_wr;   // data back next cycle
        end
    end

    assign host_rdata = mem_rdata;

    // display slots win, host fills the rest
    always_comb begin
        mem_sel   = 1'b0;
        mem_wr    = 1'b0;
        mem_mask  = '0;
        mem_addr  = held_addr;
        mem_wdata = held_wdata;
        if (slot == SLOT_MAP_RD) begin
            mem_sel  = 1'b1;
            mem_addr = fetch_map_addr;
        end else if (slot == SLOT_FONT_RD) begin
            mem_sel  = 1'b1;
            mem_addr = fetch_font_addr;
        end else if (host_exec) begin
            mem_sel  = 1'b1;
            mem_wr   = held_wr;
            mem_mask = held_mask;
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (reset)
        !(host_wr && host_rd))
        else $error("host_wr and host_rd together");

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
        host_busy |-> !(host_wr || host_rd))
        else $error("host strobe while busy");

endmodule
